/* frontend.f */
source/frontend_pkg.sv
source/branch_predictor.sv
source/ftq.sv
source/frontend_top.sv
tests/frontend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the frontend testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

{ verilator --binary --timing -Wno-fatal --top-module frontend_tb \
    -f frontend.f -o sim_frontend \
    && ./obj_dir/sim_frontend; } > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || grep -q "TB PASSED" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation did not complete"; exit 1; }

/* source/branch_predictor.sv */
module branch_predictor #(
    parameter frontend_pkg::addr_t RESET_PC = 32'h0000_1000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_ftq_rdy,
    input  logic                       i_falsepred,
    input  logic                       i_squash_vld,
    input  frontend_pkg::addr_t        i_fp_npc,
    input  frontend_pkg::addr_t        i_squash_pc,
    output logic                       o_pred_req,
    output frontend_pkg::addr_t        o_pred_start,
    output frontend_pkg::addr_t        o_pred_end,
    output frontend_pkg::addr_t        o_pred_next,
    output frontend_pkg::addr_t        o_pred_target,
    output logic                       o_pred_taken,
    output logic                       o_pred_btb_hit,
    output frontend_pkg::branch_type_t o_pred_type,
    input  logic                       i_bpu_commit,
    input  frontend_pkg::addr_t        i_upd_start,
    input  frontend_pkg::addr_t        i_upd_fallthru,
    input  frontend_pkg::addr_t        i_upd_target,
    input  frontend_pkg::branch_type_t i_upd_type,
    input  logic                       i_upd_taken,
    input  logic                       i_upd_mispred,
    input  logic                       i_upd_btb_hit,
    output logic                       o_update_done
);

    localparam int TAG_LSB = 4 + frontend_pkg::BTB_INDEX_BITS;
    localparam int BTB_DEPTH = 1 << frontend_pkg::BTB_INDEX_BITS;

    frontend_pkg::addr_t pc;
    logic                req_q;

    logic [BTB_DEPTH-1:0]       btb_vld;
    logic [31:TAG_LSB]          btb_tag      [BTB_DEPTH];
    frontend_pkg::addr_t        btb_fallthru [BTB_DEPTH];
    frontend_pkg::addr_t        btb_target   [BTB_DEPTH];
    frontend_pkg::branch_type_t btb_type     [BTB_DEPTH];
    logic                       btb_taken    [BTB_DEPTH];

    logic [TAG_LSB-1:4]  rd_idx;
    logic [TAG_LSB-1:4]  wr_idx;
    logic                hit;
    logic                accept;
    logic                upd_fire;
    logic                upd_write;
    frontend_pkg::addr_t seq_end;

    // lookup of the block starting at pc
    assign rd_idx  = pc[TAG_LSB-1:4];
    assign hit     = btb_vld[rd_idx] && (btb_tag[rd_idx] == pc[31:TAG_LSB]);
    assign seq_end = pc + 32'(frontend_pkg::FETCH_BYTES);

    assign o_pred_req     = req_q;
    assign o_pred_start   = pc;
    assign o_pred_btb_hit = hit;
    assign o_pred_end     = hit ? btb_fallthru[rd_idx] : seq_end;
    assign o_pred_target  = hit ? btb_target[rd_idx] : seq_end;
    assign o_pred_type    = hit ? btb_type[rd_idx] : frontend_pkg::br_none;
    assign o_pred_taken   = hit && ((btb_type[rd_idx] != frontend_pkg::br_cond) ||
                                    btb_taken[rd_idx]);
    assign o_pred_next    = o_pred_taken ? o_pred_target : o_pred_end;

    // same acceptance rule as the ftq
    assign accept = req_q && i_ftq_rdy && !i_falsepred && !i_squash_vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= RESET_PC;
            req_q <= 1'b0;
        end else begin
            req_q <= 1'b1;
            if (i_squash_vld) begin
                pc <= i_squash_pc;
            end else if (i_falsepred) begin
                pc <= i_fp_npc;
            end else if (accept) begin
                pc <= o_pred_next;
            end
        end
    end

    // one ack per commit while the ftq pops on done
    assign upd_fire = i_bpu_commit && !o_update_done;
    assign wr_idx   = i_upd_start[TAG_LSB-1:4];

    // a correctly predicted hit already holds the right entry
    // but conditional branches still refresh their taken bit
    assign upd_write = upd_fire && (i_upd_mispred || !i_upd_btb_hit ||
                                    (i_upd_type == frontend_pkg::br_cond));

    always_ff @(posedge clk) begin
        if (rst) begin
            btb_vld       <= '0;
            o_update_done <= 1'b0;
        end else begin
            o_update_done <= upd_fire;
            if (upd_write) begin
                btb_vld[wr_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd_write) begin
            btb_tag[wr_idx]      <= i_upd_start[31:TAG_LSB];
            btb_fallthru[wr_idx] <= i_upd_fallthru;
            btb_target[wr_idx]   <= i_upd_target;
            btb_type[wr_idx]     <= i_upd_type;
            btb_taken[wr_idx]    <= i_upd_taken;
        end
    end

    // the ftq keeps its commit up until the ack arrives
    a_done_with_commit: assert property (
        @(posedge clk) disable iff (rst)
        o_update_done |-> i_bpu_commit
    );

endmodule

/* source/frontend_pkg.sv */
package frontend_pkg;

    // instruction address
    typedef logic [31:0] addr_t;

    // queue index, sized for the default 8-entry queue
    typedef logic [2:0] ftq_idx_t;

    // byte offset inside a fetch block, also the block size
    typedef logic [4:0] blk_off_t;

    typedef enum logic [2:0] {
        br_none,
        br_cond,
        br_jal,
        br_jalr,
        br_ret
    } branch_type_t;

    // bytes covered by one sequential predictor block
    localparam int FETCH_BYTES = 16;

    // btb indexed by start address bits 6..4
    localparam int BTB_INDEX_BITS = 3;

endpackage

/* source/frontend_top.sv */
module frontend_top #(
    parameter int                  FTQ_SIZE = 8,
    parameter frontend_pkg::addr_t RESET_PC = 32'h0000_1000
) (
    input  logic                       clk,
    input  logic                       rst,
    // instruction cache
    output logic                       o_fetch_req,
    output frontend_pkg::ftq_idx_t     o_fetch_idx,
    output frontend_pkg::addr_t        o_fetch_start,
    output frontend_pkg::blk_off_t     o_fetch_size,
    output logic                       o_fetch_taken,
    output frontend_pkg::addr_t        o_fetch_next,
    input  logic                       i_fetch_rdy,
    // predecode
    input  logic                       i_stall,
    input  logic                       i_falsepred,
    input  frontend_pkg::ftq_idx_t     i_recovery_idx,
    input  frontend_pkg::ftq_idx_t     i_fp_idx,
    input  frontend_pkg::addr_t        i_fp_npc,
    // backend
    input  logic                       i_wb_vld,
    input  frontend_pkg::ftq_idx_t     i_wb_idx,
    input  logic                       i_wb_mispred,
    input  logic                       i_wb_taken,
    input  frontend_pkg::blk_off_t     i_wb_offset,
    input  frontend_pkg::addr_t        i_wb_target,
    input  frontend_pkg::branch_type_t i_wb_type,
    input  frontend_pkg::ftq_idx_t     i_read_idx,
    output frontend_pkg::addr_t        o_read_start,
    output frontend_pkg::addr_t        o_read_next,
    input  logic                       i_commit_vld,
    input  frontend_pkg::ftq_idx_t     i_commit_idx,
    input  logic                       i_squash_vld,
    input  frontend_pkg::addr_t        i_squash_pc
);

    // predictor to queue
    logic                       pred_req;
    logic                       ftq_rdy;
    frontend_pkg::addr_t        pred_start;
    frontend_pkg::addr_t        pred_end;
    frontend_pkg::addr_t        pred_next;
    frontend_pkg::addr_t        pred_target;
    logic                       pred_taken;
    logic                       pred_btb_hit;
    frontend_pkg::branch_type_t pred_type;

    // queue to predictor update
    logic                       bpu_commit;
    logic                       update_done;
    frontend_pkg::addr_t        upd_start;
    frontend_pkg::addr_t        upd_fallthru;
    frontend_pkg::addr_t        upd_target;
    frontend_pkg::branch_type_t upd_type;
    logic                       upd_taken;
    logic                       upd_mispred;
    logic                       upd_btb_hit;

    branch_predictor #(
        .RESET_PC(RESET_PC)
    ) u_bpu (
        .clk            (clk),
        .rst            (rst),
        .i_ftq_rdy      (ftq_rdy),
        .i_falsepred    (i_falsepred),
        .i_squash_vld   (i_squash_vld),
        .i_fp_npc       (i_fp_npc),
        .i_squash_pc    (i_squash_pc),
        .o_pred_req     (pred_req),
        .o_pred_start   (pred_start),
        .o_pred_end     (pred_end),
        .o_pred_next    (pred_next),
        .o_pred_target  (pred_target),
        .o_pred_taken   (pred_taken),
        .o_pred_btb_hit (pred_btb_hit),
        .o_pred_type    (pred_type),
        .i_bpu_commit   (bpu_commit),
        .i_upd_start    (upd_start),
        .i_upd_fallthru (upd_fallthru),
        .i_upd_target   (upd_target),
        .i_upd_type     (upd_type),
        .i_upd_taken    (upd_taken),
        .i_upd_mispred  (upd_mispred),
        .i_upd_btb_hit  (upd_btb_hit),
        .o_update_done  (update_done)
    );

    ftq #(
        .FTQ_SIZE(FTQ_SIZE)
    ) u_ftq (
        .clk            (clk),
        .rst            (rst),
        .i_pred_req     (pred_req),
        .i_pred_start   (pred_start),
        .i_pred_end     (pred_end),
        .i_pred_next    (pred_next),
        .i_pred_target  (pred_target),
        .i_pred_taken   (pred_taken),
        .i_pred_btb_hit (pred_btb_hit),
        .i_pred_type    (pred_type),
        .o_ftq_rdy      (ftq_rdy),
        .o_bpu_commit   (bpu_commit),
        .o_upd_start    (upd_start),
        .o_upd_fallthru (upd_fallthru),
        .o_upd_target   (upd_target),
        .o_upd_type     (upd_type),
        .o_upd_taken    (upd_taken),
        .o_upd_mispred  (upd_mispred),
        .o_upd_btb_hit  (upd_btb_hit),
        .i_update_done  (update_done),
        .o_fetch_req    (o_fetch_req),
        .o_fetch_idx    (o_fetch_idx),
        .o_fetch_start  (o_fetch_start),
        .o_fetch_size   (o_fetch_size),
        .o_fetch_taken  (o_fetch_taken),
        .o_fetch_next   (o_fetch_next),
        .i_fetch_rdy    (i_fetch_rdy),
        .i_stall        (i_stall),
        .i_falsepred    (i_falsepred),
        .i_recovery_idx (i_recovery_idx),
        .i_fp_idx       (i_fp_idx),
        .i_fp_npc       (i_fp_npc),
        .i_wb_vld       (i_wb_vld),
        .i_wb_idx       (i_wb_idx),
        .i_wb_mispred   (i_wb_mispred),
        .i_wb_taken     (i_wb_taken),
        .i_wb_offset    (i_wb_offset),
        .i_wb_target    (i_wb_target),
        .i_wb_type      (i_wb_type),
        .i_read_idx     (i_read_idx),
        .o_read_start   (o_read_start),
        .o_read_next    (o_read_next),
        .i_commit_vld   (i_commit_vld),
        .i_commit_idx   (i_commit_idx),
        .i_squash_vld   (i_squash_vld)
    );

endmodule

/* source/ftq.sv */
module ftq #(
    parameter int FTQ_SIZE = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_pred_req,
    input  frontend_pkg::addr_t        i_pred_start,
    input  frontend_pkg::addr_t        i_pred_end,
    input  frontend_pkg::addr_t        i_pred_next,
    input  frontend_pkg::addr_t        i_pred_target,
    input  logic                       i_pred_taken,
    input  logic                       i_pred_btb_hit,
    input  frontend_pkg::branch_type_t i_pred_type,
    output logic                       o_ftq_rdy,
    output logic                       o_bpu_commit,
    output frontend_pkg::addr_t        o_upd_start,
    output frontend_pkg::addr_t        o_upd_fallthru,
    output frontend_pkg::addr_t        o_upd_target,
    output frontend_pkg::branch_type_t o_upd_type,
    output logic                       o_upd_taken,
    output logic                       o_upd_mispred,
    output logic                       o_upd_btb_hit,
    input  logic                       i_update_done,
    output logic                       o_fetch_req,
    output frontend_pkg::ftq_idx_t     o_fetch_idx,
    output frontend_pkg::addr_t        o_fetch_start,
    output frontend_pkg::blk_off_t     o_fetch_size,
    output logic                       o_fetch_taken,
    output frontend_pkg::addr_t        o_fetch_next,
    input  logic                       i_fetch_rdy,
    input  logic                       i_stall,
    input  logic                       i_falsepred,
    input  frontend_pkg::ftq_idx_t     i_recovery_idx,
    input  frontend_pkg::ftq_idx_t     i_fp_idx,
    input  frontend_pkg::addr_t        i_fp_npc,
    input  logic                       i_wb_vld,
    input  frontend_pkg::ftq_idx_t     i_wb_idx,
    input  logic                       i_wb_mispred,
    input  logic                       i_wb_taken,
    input  frontend_pkg::blk_off_t     i_wb_offset,
    input  frontend_pkg::addr_t        i_wb_target,
    input  frontend_pkg::branch_type_t i_wb_type,
    input  frontend_pkg::ftq_idx_t     i_read_idx,
    output frontend_pkg::addr_t        o_read_start,
    output frontend_pkg::addr_t        o_read_next,
    input  logic                       i_commit_vld,
    input  frontend_pkg::ftq_idx_t     i_commit_idx,
    input  logic                       i_squash_vld
);

    frontend_pkg::ftq_idx_t pred_ptr;
    frontend_pkg::ftq_idx_t fetch_ptr;
    frontend_pkg::ftq_idx_t commit_ptr;
    frontend_pkg::ftq_idx_t commit_thre;
    frontend_pkg::ftq_idx_t next_thre;
    logic                   pred_wrap;
    logic                   fetch_wrap;
    logic                   commit_wrap;
    logic                   rewind_wrap;
    logic [FTQ_SIZE-1:0]    entry_vld;

    // block fields
    frontend_pkg::addr_t        ent_start      [FTQ_SIZE];
    frontend_pkg::addr_t        ent_end        [FTQ_SIZE];
    frontend_pkg::addr_t        ent_next       [FTQ_SIZE];
    logic                       ent_pred_taken [FTQ_SIZE];
    logic                       ent_btb_hit    [FTQ_SIZE];
    // branch fields, refined by the backend writeback
    logic                       ent_written    [FTQ_SIZE];
    logic                       ent_mispred    [FTQ_SIZE];
    logic                       ent_br_taken   [FTQ_SIZE];
    frontend_pkg::blk_off_t     ent_offset     [FTQ_SIZE];
    frontend_pkg::addr_t        ent_target     [FTQ_SIZE];
    frontend_pkg::branch_type_t ent_type       [FTQ_SIZE];

    logic full;
    logic do_pred;
    logic bypass;
    logic fetch_pending;
    logic do_commit;
    logic pop;

    function automatic logic at_last(input frontend_pkg::ftq_idx_t p);
        return int'(p) == FTQ_SIZE - 1;
    endfunction

    function automatic frontend_pkg::ftq_idx_t ptr_inc(input frontend_pkg::ftq_idx_t p);
        return at_last(p) ? '0 : p + 1'b1;
    endfunction

    // circular window [lo, hi)
    function automatic logic in_window(input int i, input frontend_pkg::ftq_idx_t lo,
                                       input frontend_pkg::ftq_idx_t hi);
        if (lo <= hi) begin
            return (i >= int'(lo)) && (i < int'(hi));
        end
        return (i >= int'(lo)) || (i < int'(hi));
    endfunction

    assign full      = (commit_ptr == pred_ptr) && (commit_wrap != pred_wrap);
    assign o_ftq_rdy = !full;
    assign do_pred   = i_pred_req && !full && !i_falsepred && !i_squash_vld;

    // nothing unfetched, so the new block goes straight to the cache
    assign fetch_pending = (fetch_ptr != pred_ptr) || (fetch_wrap != pred_wrap);
    assign bypass        = do_pred && !fetch_pending;
    assign o_fetch_req   = !i_stall && !i_falsepred && !i_squash_vld &&
                           (fetch_pending || bypass);

    assign do_commit    = commit_ptr != commit_thre;
    assign o_bpu_commit = do_commit && (ent_type[commit_ptr] != frontend_pkg::br_none);
    assign pop          = do_commit && (!o_bpu_commit || i_update_done);

    assign next_thre   = i_commit_vld ? i_commit_idx : commit_thre;
    assign rewind_wrap = (i_recovery_idx > pred_ptr) ? !pred_wrap : pred_wrap;

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_ptr    <= '0;
            fetch_ptr   <= '0;
            commit_ptr  <= '0;
            commit_thre <= '0;
            pred_wrap   <= 1'b0;
            fetch_wrap  <= 1'b0;
            commit_wrap <= 1'b0;
            entry_vld   <= '0;
        end else begin
            if (i_squash_vld) begin
                // keep only what the backend has already committed
                pred_ptr   <= next_thre;
                fetch_ptr  <= next_thre;
                pred_wrap  <= (next_thre >= commit_ptr) ? commit_wrap : !commit_wrap;
                fetch_wrap <= (next_thre >= commit_ptr) ? commit_wrap : !commit_wrap;
                for (int i = 0; i < FTQ_SIZE; i++) begin
                    if (!in_window(i, commit_ptr, next_thre)) begin
                        entry_vld[i] <= 1'b0;
                    end
                end
            end else begin
                if (i_falsepred) begin
                    pred_ptr  <= i_recovery_idx;
                    pred_wrap <= rewind_wrap;
                    for (int i = 0; i < FTQ_SIZE; i++) begin
                        if (in_window(i, i_recovery_idx, pred_ptr)) begin
                            entry_vld[i] <= 1'b0;
                        end
                    end
                end else if (do_pred) begin
                    entry_vld[pred_ptr] <= 1'b1;
                    pred_ptr            <= ptr_inc(pred_ptr);
                    pred_wrap           <= pred_wrap ^ at_last(pred_ptr);
                end

                if (i_stall || i_falsepred) begin
                    fetch_ptr  <= i_recovery_idx;
                    fetch_wrap <= rewind_wrap;
                end else if (o_fetch_req && i_fetch_rdy) begin
                    fetch_ptr  <= ptr_inc(fetch_ptr);
                    fetch_wrap <= fetch_wrap ^ at_last(fetch_ptr);
                end
            end

            if (pop) begin
                entry_vld[commit_ptr] <= 1'b0;
                commit_ptr            <= ptr_inc(commit_ptr);
                commit_wrap           <= commit_wrap ^ at_last(commit_ptr);
            end
            if (i_commit_vld) begin
                commit_thre <= i_commit_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_read_start <= ent_start[i_read_idx];
        o_read_next  <= ent_next[i_read_idx];

        if (do_pred) begin
            ent_start[pred_ptr]      <= i_pred_start;
            ent_end[pred_ptr]        <= i_pred_end;
            ent_next[pred_ptr]       <= i_pred_next;
            ent_pred_taken[pred_ptr] <= i_pred_taken;
            ent_btb_hit[pred_ptr]    <= i_pred_btb_hit;
            ent_written[pred_ptr]    <= 1'b0;
            ent_mispred[pred_ptr]    <= 1'b0;
            ent_br_taken[pred_ptr]   <= i_pred_taken;
            ent_offset[pred_ptr]     <= frontend_pkg::blk_off_t'(i_pred_end - i_pred_start);
            ent_target[pred_ptr]     <= i_pred_target;
            ent_type[pred_ptr]       <= i_pred_type;
        end
        if (i_wb_vld) begin
            ent_written[i_wb_idx]  <= 1'b1;
            ent_mispred[i_wb_idx]  <= i_wb_mispred;
            ent_br_taken[i_wb_idx] <= i_wb_taken;
            ent_offset[i_wb_idx]   <= i_wb_offset;
            ent_target[i_wb_idx]   <= i_wb_target;
            ent_type[i_wb_idx]     <= i_wb_type;
        end
        // predecode corrected the stream after this block
        if (i_falsepred) begin
            ent_next[i_fp_idx] <= i_fp_npc;
        end
    end

    assign o_fetch_idx   = fetch_ptr;
    assign o_fetch_start = bypass ? i_pred_start : ent_start[fetch_ptr];
    assign o_fetch_size  = bypass ? frontend_pkg::blk_off_t'(i_pred_end - i_pred_start) :
                           frontend_pkg::blk_off_t'(ent_end[fetch_ptr] - ent_start[fetch_ptr]);
    assign o_fetch_taken = bypass ? i_pred_taken : ent_pred_taken[fetch_ptr];
    assign o_fetch_next  = bypass ? i_pred_next : ent_next[fetch_ptr];

    assign o_upd_start    = ent_start[commit_ptr];
    assign o_upd_fallthru = ent_start[commit_ptr] + 32'(ent_offset[commit_ptr]);
    assign o_upd_target   = ent_target[commit_ptr];
    assign o_upd_type     = ent_type[commit_ptr];
    assign o_upd_taken    = ent_br_taken[commit_ptr];
    assign o_upd_mispred  = ent_mispred[commit_ptr];
    assign o_upd_btb_hit  = ent_btb_hit[commit_ptr];

    a_push_free: assert property (
        @(posedge clk) disable iff (rst)
        do_pred |-> !entry_vld[pred_ptr]
    );

    a_wb_once: assert property (
        @(posedge clk) disable iff (rst)
        i_wb_vld |-> entry_vld[i_wb_idx] && !ent_written[i_wb_idx]
    );

    a_pop_valid: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> entry_vld[commit_ptr]
    );

endmodule

/* tests/frontend_input.txt */
# command followed by four hex operands a b c d, unused operands are 0
# fetch/hold/flow a=count, commit a=index, wb a=index b=offset c=target d=type
# read a=index b=start c=next, falsepred a=fp index b=recovery index c=npc, squash a=pc
fetch 5 0 0 0
hold 6 0 0 0
fetch 3 0 0 0
commit 6 0 0 0
fetch 4 0 0 0
read 2 000010a0 000010b0 0
wb 1 0c 00002000 2
commit 3 0 0 0
squash 00001090 0 0 0
fetch 3 0 0 0
hold 3 0 0 0
read 3 00001090 00002000 0
falsepred 5 6 00003000 0
fetch 2 0 0 0
read 5 00002010 00003000 0
flow c 0 0 0
hold 2 0 0 0

/* tests/frontend_tb.sv */
module frontend_tb;

    logic                       clk;
    logic                       rst;
    logic                       o_fetch_req;
    frontend_pkg::ftq_idx_t     o_fetch_idx;
    frontend_pkg::addr_t        o_fetch_start;
    frontend_pkg::blk_off_t     o_fetch_size;
    logic                       o_fetch_taken;
    frontend_pkg::addr_t        o_fetch_next;
    logic                       i_fetch_rdy;
    logic                       i_stall;
    logic                       i_falsepred;
    frontend_pkg::ftq_idx_t     i_recovery_idx;
    frontend_pkg::ftq_idx_t     i_fp_idx;
    frontend_pkg::addr_t        i_fp_npc;
    logic                       i_wb_vld;
    frontend_pkg::ftq_idx_t     i_wb_idx;
    logic                       i_wb_mispred;
    logic                       i_wb_taken;
    frontend_pkg::blk_off_t     i_wb_offset;
    frontend_pkg::addr_t        i_wb_target;
    frontend_pkg::branch_type_t i_wb_type;
    frontend_pkg::ftq_idx_t     i_read_idx;
    frontend_pkg::addr_t        o_read_start;
    frontend_pkg::addr_t        o_read_next;
    logic                       i_commit_vld;
    frontend_pkg::ftq_idx_t     i_commit_idx;
    logic                       i_squash_vld;
    frontend_pkg::addr_t        i_squash_pc;

    frontend_top UUT (.*);

    // predictor model with one btb entry per index and tag pc[31:7]
    logic                btb_vld   [8];
    logic [31:7]         btb_tag   [8];
    frontend_pkg::addr_t btb_fall  [8];
    frontend_pkg::addr_t btb_tgt   [8];
    logic [2:0]          btb_type  [8];
    logic                btb_taken [8];

    frontend_pkg::addr_t    model_pc;
    frontend_pkg::ftq_idx_t exp_idx;
    frontend_pkg::ftq_idx_t commit_thre;
    frontend_pkg::addr_t    fetched_start [8];

    // writeback waiting for its commit
    logic                upd_pending;
    frontend_pkg::addr_t upd_start;
    frontend_pkg::addr_t upd_fall;
    frontend_pkg::addr_t upd_tgt;
    logic [2:0]          upd_type;

    string        cmd_q [$];
    logic [31:0]  opa_q [$];
    logic [31:0]  opb_q [$];
    logic [31:0]  opc_q [$];
    logic [31:0]  opd_q [$];
    int           cycles;
    int           limit;
    integer       seed;

    always #2 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("TB FAILED");
            $fatal(1);
        end
        i_commit_vld = 1'b0;
        i_wb_vld     = 1'b0;
        i_falsepred  = 1'b0;
        i_squash_vld = 1'b0;
        i_stall      = 1'b0;
    endtask

    // block prediction from the model btb
    task automatic predict_block(input frontend_pkg::addr_t pc,
                                 output frontend_pkg::addr_t nxt,
                                 output frontend_pkg::blk_off_t size,
                                 output logic taken);
        logic [2:0]          idx;
        logic                hit;
        frontend_pkg::addr_t blk_end;
        idx     = pc[6:4];
        hit     = btb_vld[idx] && (btb_tag[idx] == pc[31:7]);
        blk_end = hit ? btb_fall[idx] : pc + 32'd16;
        taken   = hit && ((btb_type[idx] != 3'd1) || btb_taken[idx]);
        nxt     = taken ? btb_tgt[idx] : blk_end;
        size    = frontend_pkg::blk_off_t'(blk_end - pc);
    endtask

    task automatic check_fetch();
        frontend_pkg::addr_t    nxt;
        frontend_pkg::blk_off_t size;
        logic                   taken;
        predict_block(model_pc, nxt, size, taken);
        check_value(32'(o_fetch_idx), 32'(exp_idx), "fetch index");
        check_value(o_fetch_start, model_pc, "fetch start");
        check_value(32'(o_fetch_size), 32'(size), "fetch size");
        check_value(32'(o_fetch_taken), 32'(taken), "fetch taken");
        check_value(o_fetch_next, nxt, "fetch next");
        fetched_start[exp_idx] = model_pc;
        model_pc = nxt;
        exp_idx  = exp_idx + 3'd1;
    endtask

    task automatic load_commands();
        integer      fd;
        integer      code;
        string       cmd;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          total;
        total = 0;
        fd = $fopen("tests/frontend_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/frontend_input.txt");
            $display("TB FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) break;
            if (cmd == "#") begin
                code = $fgets(line, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                cmd_q.push_back(cmd);
                opa_q.push_back(a);
                opb_q.push_back(b);
                opc_q.push_back(c);
                opd_q.push_back(d);
                if (cmd == "fetch" || cmd == "hold" || cmd == "flow") total += int'(a);
                else if (cmd == "commit") total += 16;
                else total += 2;
            end
        end
        $fclose(fd);
        limit = total * 4 + 100;
    endtask

    task automatic run_command(input string cmd, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] c, input logic [31:0] d);
        int          count;
        integer      rnd;
        logic        accepted;
        logic [2:0]  last_idx;
        count    = 0;
        accepted = 1'b0;
        last_idx = '0;
        if (cmd == "fetch") begin
            while (count < int'(a)) begin
                next_cycle();
                rnd = $random(seed);
                i_fetch_rdy = rnd[0];
                #2;
                if (o_fetch_req && i_fetch_rdy) begin
                    check_fetch();
                    count++;
                end
            end
        end else if (cmd == "hold") begin
            repeat (int'(a)) begin
                next_cycle();
                i_fetch_rdy = 1'b0;
                #2;
                check_value(32'(o_fetch_req), 32'd1, "held fetch request");
                check_value(32'(o_fetch_idx), 32'(exp_idx), "held fetch index");
                check_value(o_fetch_start, model_pc, "held fetch start");
            end
        end else if (cmd == "flow") begin
            // rdy stays high and every accepted block moves the commit point up
            while (count < int'(a)) begin
                next_cycle();
                i_fetch_rdy = 1'b1;
                if (accepted) begin
                    i_commit_vld = 1'b1;
                    i_commit_idx = last_idx;
                    commit_thre  = last_idx;
                end
                #2;
                accepted = o_fetch_req;
                if (o_fetch_req) begin
                    last_idx = o_fetch_idx;
                    check_fetch();
                    count++;
                end
            end
        end else if (cmd == "commit") begin
            next_cycle();
            i_fetch_rdy  = 1'b0;
            i_commit_vld = 1'b1;
            i_commit_idx = a[2:0];
            commit_thre  = a[2:0];
            if (upd_pending) begin
                btb_vld[upd_start[6:4]]   = 1'b1;
                btb_tag[upd_start[6:4]]   = upd_start[31:7];
                btb_fall[upd_start[6:4]]  = upd_fall;
                btb_tgt[upd_start[6:4]]   = upd_tgt;
                btb_type[upd_start[6:4]]  = upd_type;
                btb_taken[upd_start[6:4]] = 1'b1;
                upd_pending = 1'b0;
            end
            next_cycle();
            while (UUT.u_ftq.commit_ptr != a[2:0]) begin
                next_cycle();
            end
        end else if (cmd == "wb") begin
            next_cycle();
            i_fetch_rdy  = 1'b0;
            i_wb_vld     = 1'b1;
            i_wb_idx     = a[2:0];
            i_wb_mispred = 1'b1;
            i_wb_taken   = 1'b1;
            i_wb_offset  = b[4:0];
            i_wb_target  = c;
            i_wb_type    = frontend_pkg::branch_type_t'(d[2:0]);
            upd_pending  = 1'b1;
            upd_start    = fetched_start[a[2:0]];
            upd_fall     = fetched_start[a[2:0]] + 32'(b[4:0]);
            upd_tgt      = c;
            upd_type     = d[2:0];
        end else if (cmd == "read") begin
            next_cycle();
            i_fetch_rdy = 1'b0;
            i_read_idx  = a[2:0];
            next_cycle();
            #2;
            check_value(o_read_start, b, "read start");
            check_value(o_read_next, c, "read next");
        end else if (cmd == "falsepred") begin
            next_cycle();
            i_fetch_rdy    = 1'b0;
            i_falsepred    = 1'b1;
            i_fp_idx       = a[2:0];
            i_recovery_idx = b[2:0];
            i_fp_npc       = c;
            model_pc       = c;
            exp_idx        = b[2:0];
        end else if (cmd == "squash") begin
            next_cycle();
            i_fetch_rdy  = 1'b0;
            i_squash_vld = 1'b1;
            i_squash_pc  = a;
            model_pc     = a;
            exp_idx      = commit_thre;
        end else begin
            $display("unknown command in the stimulus file: %s", cmd);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_fetch_rdy    = 1'b0;
        i_stall        = 1'b0;
        i_falsepred    = 1'b0;
        i_recovery_idx = '0;
        i_fp_idx       = '0;
        i_fp_npc       = '0;
        i_wb_vld       = 1'b0;
        i_wb_idx       = '0;
        i_wb_mispred   = 1'b0;
        i_wb_taken     = 1'b0;
        i_wb_offset    = '0;
        i_wb_target    = '0;
        i_wb_type      = frontend_pkg::br_none;
        i_read_idx     = '0;
        i_commit_vld   = 1'b0;
        i_commit_idx   = '0;
        i_squash_vld   = 1'b0;
        i_squash_pc    = '0;
        seed        = 32'h63d6_062b;
        cycles      = 0;
        model_pc    = 32'h0000_1000;
        exp_idx     = '0;
        commit_thre = '0;
        upd_pending = 1'b0;
        for (int i = 0; i < 8; i++) begin
            btb_vld[i] = 1'b0;
        end
        load_commands();

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (cmd_q[i]) begin
            run_command(cmd_q[i], opa_q[i], opb_q[i], opc_q[i], opd_q[i]);
        end
        next_cycle();
        $display("TB PASSED");
        $finish;
    end

endmodule
